// File: hw/dma_pkg.sv
package dma_pkg;

    localparam int NUM_CH = 4;
    localparam int CH_W   = $clog2(NUM_CH);
    localparam int ADDR_W = 16;
    localparam int BYTE_W = 8;

    // CPU register map, 0..7 are the per-channel address/count pairs
    typedef enum logic [3:0] {
        REG_CH0_ADDR     = 4'd0,
        REG_CH0_COUNT    = 4'd1,
        REG_CH1_ADDR     = 4'd2,
        REG_CH1_COUNT    = 4'd3,
        REG_CH2_ADDR     = 4'd4,
        REG_CH2_COUNT    = 4'd5,
        REG_CH3_ADDR     = 4'd6,
        REG_CH3_COUNT    = 4'd7,
        REG_CMD_STATUS   = 4'd8,
        REG_REQUEST      = 4'd9,
        REG_SINGLE_MASK  = 4'd10,
        REG_MODE         = 4'd11,
        REG_CLEAR_PTR    = 4'd12,
        REG_MASTER_CLEAR = 4'd13,
        REG_CLEAR_MASK   = 4'd14,
        REG_WRITE_MASK   = 4'd15
    } reg_addr_t;

    typedef enum logic [1:0] {
        XFER_VERIFY  = 2'd0,
        XFER_WRITE   = 2'd1,
        XFER_READ    = 2'd2,
        XFER_ILLEGAL = 2'd3
    } xfer_t;

    typedef struct packed {
        xfer_t xfer;
        logic  autoinit;
        logic  decrement;
    } chan_mode_t;

    typedef struct packed {
        logic              wr;
        logic              rd;
        reg_addr_t         addr;
        logic [BYTE_W-1:0] data;
    } cpu_req_t;

    typedef struct packed {
        logic              addr_we;
        logic              count_we;
        logic              mode_we;
        logic              hi_byte;
        logic [BYTE_W-1:0] data;
    } chan_wr_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] count;
        chan_mode_t        mode;
    } chan_state_t;

    typedef struct packed {
        logic              aen;
        logic              adstb;
        logic [ADDR_W-1:0] addr;
        logic              memr;
        logic              memw;
        logic              ior;
        logic              iow;
    } dma_bus_t;

    typedef enum logic [2:0] {
        IDLE,
        S0,
        S1,
        S2,
        S3,
        S4
    } cycle_state_t;

endpackage

// File: hw/dma_channel.sv
module dma_channel (
    input  logic                 clk,
    input  logic                 reset,
    input  dma_pkg::chan_wr_t    wr,
    input  logic                 step,
    output dma_pkg::chan_state_t state,
    output logic                 tc
);

    logic [dma_pkg::ADDR_W-1:0] base_addr;
    logic [dma_pkg::ADDR_W-1:0] base_count;
    logic [dma_pkg::ADDR_W-1:0] cur_addr;
    logic [dma_pkg::ADDR_W-1:0] cur_count;
    dma_pkg::chan_mode_t        mode;
    logic                       count_zero;

    assign count_zero = (cur_count == '0);

    // Terminal count is the step taken with the count already at zero
    assign tc = step && count_zero;

    assign state.addr  = cur_addr;
    assign state.count = cur_count;
    assign state.mode  = mode;

    always_ff @(posedge clk) begin
        if (step) begin
            if (count_zero && mode.autoinit) begin
                cur_addr  <= base_addr;
                cur_count <= base_count;
            end else begin
                cur_count <= cur_count - 1'b1;
                if (mode.decrement) begin
                    cur_addr <= cur_addr - 1'b1;
                end else begin
                    cur_addr <= cur_addr + 1'b1;
                end
            end
        end

        // CPU byte writes come last so they override a step on the same edge
        if (wr.addr_we) begin
            if (wr.hi_byte) begin
                base_addr[dma_pkg::ADDR_W-1:dma_pkg::BYTE_W] <= wr.data;
                cur_addr[dma_pkg::ADDR_W-1:dma_pkg::BYTE_W]  <= wr.data;
            end else begin
                base_addr[dma_pkg::BYTE_W-1:0] <= wr.data;
                cur_addr[dma_pkg::BYTE_W-1:0]  <= wr.data;
            end
        end

        if (wr.count_we) begin
            if (wr.hi_byte) begin
                base_count[dma_pkg::ADDR_W-1:dma_pkg::BYTE_W] <= wr.data;
                cur_count[dma_pkg::ADDR_W-1:dma_pkg::BYTE_W]  <= wr.data;
            end else begin
                base_count[dma_pkg::BYTE_W-1:0] <= wr.data;
                cur_count[dma_pkg::BYTE_W-1:0]  <= wr.data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mode <= '0;
        end else if (wr.mode_we) begin
            // Mode byte: [3:2] transfer type, [4] autoinit, [5] decrement
            mode.xfer      <= dma_pkg::xfer_t'(wr.data[3:2]);
            mode.autoinit  <= wr.data[4];
            mode.decrement <= wr.data[5];
        end
    end

endmodule

// File: hw/dma_arbiter.sv
module dma_arbiter (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        mclr,
    input  logic [dma_pkg::NUM_CH-1:0]  eligible,
    input  dma_pkg::chan_state_t        chan [dma_pkg::NUM_CH],
    input  logic                        lock,
    input  logic                        step,
    output logic                        any_req,
    output logic                        granted_req,
    output logic [dma_pkg::NUM_CH-1:0]  grant,
    output dma_pkg::chan_state_t        sel_state,
    output logic [dma_pkg::NUM_CH-1:0]  chan_step
);

    logic [dma_pkg::NUM_CH-1:0] next_grant;

    // Lowest set bit wins, channel 0 first
    assign next_grant = eligible & (~eligible + 1'b1);

    assign any_req     = |eligible;
    assign granted_req = |(eligible & grant);
    assign chan_step   = grant & {dma_pkg::NUM_CH{step}};

    always_ff @(posedge clk) begin
        if (reset || mclr) begin
            grant <= '0;
        end else if (lock) begin
            grant <= next_grant;
        end else if (step) begin
            grant <= '0;
        end
    end

    always_comb begin
        sel_state = '0;
        for (int i = 0; i < dma_pkg::NUM_CH; i++) begin
            if (grant[i]) begin
                sel_state = chan[i];
            end
        end
    end

    grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant));

endmodule

// File: hw/dma_cpu_port.sv
module dma_cpu_port (
    input  logic                        clk,
    input  logic                        reset,
    input  dma_pkg::cpu_req_t           cpu,
    input  logic [dma_pkg::NUM_CH-1:0]  dreq,
    input  logic [dma_pkg::NUM_CH-1:0]  tc,
    input  dma_pkg::chan_state_t        chan [dma_pkg::NUM_CH],
    output dma_pkg::chan_wr_t           chan_wr [dma_pkg::NUM_CH],
    output logic [dma_pkg::NUM_CH-1:0]  eligible,
    output logic                        mclr,
    output logic [dma_pkg::BYTE_W-1:0]  rdata,
    output logic                        rdata_valid
);

    logic                       byte_ptr;
    logic                       cmd_disable;
    logic [dma_pkg::NUM_CH-1:0] mask;
    logic [dma_pkg::NUM_CH-1:0] request;
    logic [dma_pkg::NUM_CH-1:0] status_tc;
    logic                       chan_reg;
    logic [dma_pkg::CH_W-1:0]   ch_sel;
    logic                       mode_wr;
    logic                       status_rd;
    dma_pkg::chan_state_t       rd_chan;
    logic [dma_pkg::ADDR_W-1:0] rd_word;
    logic [dma_pkg::BYTE_W-1:0] rd_byte;

    // Addresses 0..7 select channel in [2:1], count in [0]
    assign chan_reg  = !cpu.addr[3];
    assign ch_sel    = cpu.addr[2:1];
    assign mode_wr   = cpu.wr && (cpu.addr == dma_pkg::REG_MODE)
                       && (cpu.data[3:2] != dma_pkg::XFER_ILLEGAL);
    assign status_rd = cpu.rd && (cpu.addr == dma_pkg::REG_CMD_STATUS);
    assign mclr      = cpu.wr && (cpu.addr == dma_pkg::REG_MASTER_CLEAR);

    // Software request bypasses the mask
    assign eligible = ((dreq & ~mask) | request) & {dma_pkg::NUM_CH{!cmd_disable}};

    always_comb begin
        for (int i = 0; i < dma_pkg::NUM_CH; i++) begin
            chan_wr[i].addr_we  = cpu.wr && chan_reg && (ch_sel == dma_pkg::CH_W'(i))
                                  && !cpu.addr[0];
            chan_wr[i].count_we = cpu.wr && chan_reg && (ch_sel == dma_pkg::CH_W'(i))
                                  && cpu.addr[0];
            chan_wr[i].mode_we  = mode_wr && (cpu.data[1:0] == dma_pkg::CH_W'(i));
            chan_wr[i].hi_byte  = byte_ptr;
            chan_wr[i].data     = cpu.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || mclr) begin
            byte_ptr    <= 1'b0;
            cmd_disable <= 1'b0;
            mask        <= '1;
            request     <= '0;
            status_tc   <= '0;
        end else begin
            if ((cpu.wr || cpu.rd) && chan_reg) begin
                byte_ptr <= !byte_ptr;
            end

            // A new TC is never lost to the clearing read
            status_tc <= (status_rd ? '0 : status_tc) | tc;

            for (int i = 0; i < dma_pkg::NUM_CH; i++) begin
                if (tc[i]) begin
                    request[i] <= 1'b0;
                    if (!chan[i].mode.autoinit) begin
                        mask[i] <= 1'b1;
                    end
                end
            end

            if (cpu.wr) begin
                case (cpu.addr)
                    dma_pkg::REG_CMD_STATUS: cmd_disable <= cpu.data[2];
                    dma_pkg::REG_REQUEST: request[cpu.data[1:0]] <= cpu.data[2];
                    dma_pkg::REG_SINGLE_MASK: mask[cpu.data[1:0]] <= cpu.data[2];
                    dma_pkg::REG_CLEAR_PTR: byte_ptr <= 1'b0;
                    dma_pkg::REG_CLEAR_MASK: mask <= '0;
                    dma_pkg::REG_WRITE_MASK: mask <= cpu.data[dma_pkg::NUM_CH-1:0];
                    default: ;
                endcase
            end
        end
    end

    assign rd_chan = chan[ch_sel];
    assign rd_word = cpu.addr[0] ? rd_chan.count : rd_chan.addr;

    always_comb begin
        rd_byte = '0;
        if (chan_reg) begin
            rd_byte = byte_ptr ? rd_word[dma_pkg::ADDR_W-1:dma_pkg::BYTE_W]
                               : rd_word[dma_pkg::BYTE_W-1:0];
        end else if (cpu.addr == dma_pkg::REG_CMD_STATUS) begin
            // Pending requests high, TC flags low
            rd_byte = {dreq | request, status_tc};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= cpu.rd;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu.rd) begin
            rdata <= rd_byte;
        end
    end

    cpu_no_wr_rd: assert property (@(posedge clk) disable iff (reset) !(cpu.wr && cpu.rd));

endmodule

// File: hw/dma_cycle_fsm.sv
module dma_cycle_fsm (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        mclr,
    input  logic                        any_req,
    input  logic                        granted_req,
    input  dma_pkg::chan_state_t        sel_state,
    input  logic [dma_pkg::NUM_CH-1:0]  grant,
    input  logic                        hlda,
    output logic                        hrq,
    output logic [dma_pkg::NUM_CH-1:0]  dack,
    output dma_pkg::dma_bus_t           bus,
    output logic                        eop,
    output logic                        lock,
    output logic                        step
);

    dma_pkg::cycle_state_t state;
    dma_pkg::cycle_state_t state_next;
    logic                  drive_addr;
    logic                  drive_strobe;
    logic                  xfer_wr;
    logic                  xfer_rd;

    always_comb begin
        state_next = state;
        case (state)
            dma_pkg::IDLE: begin
                if (any_req) begin
                    state_next = dma_pkg::S0;
                end
            end
            dma_pkg::S0: begin
                // Request withdrawn while waiting for the bus
                if (!granted_req) begin
                    state_next = dma_pkg::IDLE;
                end else if (hlda) begin
                    state_next = dma_pkg::S1;
                end
            end
            dma_pkg::S1: state_next = dma_pkg::S2;
            dma_pkg::S2: state_next = dma_pkg::S3;
            dma_pkg::S3: state_next = dma_pkg::S4;
            default: state_next = dma_pkg::IDLE;
        endcase
        if (mclr) begin
            state_next = dma_pkg::IDLE;
        end
    end

    assign lock = (state == dma_pkg::IDLE) && (state_next == dma_pkg::S0);
    assign step = (state == dma_pkg::S4);

    // Outputs are registered from the next state so they line up with it
    assign drive_addr   = state_next inside {dma_pkg::S2, dma_pkg::S3, dma_pkg::S4};
    assign drive_strobe = state_next inside {dma_pkg::S3, dma_pkg::S4};
    assign xfer_wr      = drive_strobe && (sel_state.mode.xfer == dma_pkg::XFER_WRITE);
    assign xfer_rd      = drive_strobe && (sel_state.mode.xfer == dma_pkg::XFER_READ);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dma_pkg::IDLE;
            hrq   <= 1'b0;
            dack  <= '0;
            bus   <= '0;
            eop   <= 1'b0;
        end else begin
            state     <= state_next;
            hrq       <= (state_next != dma_pkg::IDLE);
            dack      <= drive_addr ? grant : '0;
            bus.aen   <= state_next inside {dma_pkg::S1, dma_pkg::S2, dma_pkg::S3,
                                            dma_pkg::S4};
            bus.adstb <= (state_next == dma_pkg::S2);
            bus.addr  <= drive_addr ? sel_state.addr : '0;
            // Write is I/O to memory, read is memory to I/O
            bus.ior   <= xfer_wr;
            bus.memw  <= xfer_wr;
            bus.iow   <= xfer_rd;
            bus.memr  <= xfer_rd;
            eop       <= (state_next == dma_pkg::S4) && (sel_state.count == '0);
        end
    end

    mem_strobes_excl: assert property (@(posedge clk) disable iff (reset)
        !(bus.memr && bus.memw));

    dack_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(dack));

    dack_with_aen: assert property (@(posedge clk) disable iff (reset)
        (|dack) |-> bus.aen);

endmodule

// File: hw/dma_controller.sv
module dma_controller (
    input  logic                        clk,
    input  logic                        reset,
    input  dma_pkg::cpu_req_t           cpu,
    output logic [dma_pkg::BYTE_W-1:0]  rdata,
    output logic                        rdata_valid,
    input  logic [dma_pkg::NUM_CH-1:0]  dreq,
    input  logic                        hlda,
    output logic                        hrq,
    output logic [dma_pkg::NUM_CH-1:0]  dack,
    output dma_pkg::dma_bus_t           bus,
    output logic                        eop
);

    dma_pkg::chan_wr_t          chan_wr [dma_pkg::NUM_CH];
    dma_pkg::chan_state_t       chan_state [dma_pkg::NUM_CH];
    logic [dma_pkg::NUM_CH-1:0] tc;
    logic [dma_pkg::NUM_CH-1:0] eligible;
    logic                       mclr;
    logic                       any_req;
    logic                       granted_req;
    logic [dma_pkg::NUM_CH-1:0] grant;
    dma_pkg::chan_state_t       sel_state;
    logic [dma_pkg::NUM_CH-1:0] chan_step;
    logic                       lock;
    logic                       step;

    dma_cpu_port u_cpu_port (
        .clk         (clk),
        .reset       (reset),
        .cpu         (cpu),
        .dreq        (dreq),
        .tc          (tc),
        .chan        (chan_state),
        .chan_wr     (chan_wr),
        .eligible    (eligible),
        .mclr        (mclr),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    for (genvar i = 0; i < dma_pkg::NUM_CH; i++) begin : g_chan
        dma_channel u_channel (
            .clk   (clk),
            .reset (reset),
            .wr    (chan_wr[i]),
            .step  (chan_step[i]),
            .state (chan_state[i]),
            .tc    (tc[i])
        );
    end

    dma_arbiter u_arbiter (
        .clk         (clk),
        .reset       (reset),
        .mclr        (mclr),
        .eligible    (eligible),
        .chan        (chan_state),
        .lock        (lock),
        .step        (step),
        .any_req     (any_req),
        .granted_req (granted_req),
        .grant       (grant),
        .sel_state   (sel_state),
        .chan_step   (chan_step)
    );

    dma_cycle_fsm u_cycle_fsm (
        .clk         (clk),
        .reset       (reset),
        .mclr        (mclr),
        .any_req     (any_req),
        .granted_req (granted_req),
        .sel_state   (sel_state),
        .grant       (grant),
        .hlda        (hlda),
        .hrq         (hrq),
        .dack        (dack),
        .bus         (bus),
        .eop         (eop),
        .lock        (lock),
        .step        (step)
    );

endmodule

// File: sim/dma_checker.sv
module dma_checker (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [dma_pkg::BYTE_W-1:0]  rdata,
    input  logic                        rdata_valid,
    input  logic [dma_pkg::NUM_CH-1:0]  dack,
    input  dma_pkg::dma_bus_t           bus,
    input  logic                        eop,
    input  logic                        rd_armed,
    input  logic [dma_pkg::BYTE_W-1:0]  exp_rdata,
    input  logic                        xfer_armed,
    input  logic [1:0]                  exp_ch,
    input  logic [dma_pkg::ADDR_W-1:0]  exp_addr,
    input  dma_pkg::xfer_t              exp_xfer,
    input  logic                        exp_eop
);

    int         err_count = 0;
    int         test_errs = 0;
    int         test_count = 0;
    int         failed_tests = 0;
    int         phase = 0;
    logic [3:0] exp_strobes;
    logic [3:0] strobes;

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        err_count++;
        test_errs++;
    endtask

    task automatic report_failure(input string msg);
        $display("Failure: %s", msg);
        err_count++;
        test_errs++;
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (test_errs == 0) begin
            $display("test %0d, %s: pass", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d, %s: fail with %0d errors", test_count, name, test_errs);
        end
        test_errs = 0;
    endtask

    task automatic close_run();
        $display("%0d tests run, %0d failed, %0d errors", test_count, failed_tests, err_count);
    endtask

    // Order is memr, memw, ior, iow
    assign strobes = {bus.memr, bus.memw, bus.ior, bus.iow};

    always_comb begin
        case (exp_xfer)
            dma_pkg::XFER_WRITE: exp_strobes = 4'b0110;
            dma_pkg::XFER_READ:  exp_strobes = 4'b1001;
            default:             exp_strobes = 4'b0000;
        endcase
    end

    always @(posedge clk) begin
        if (reset) begin
            phase = 0;
        end else begin
            if (rdata_valid) begin
                if (!rd_armed) begin
                    report_failure("read data returned with no read pending");
                end else if (rdata !== exp_rdata) begin
                    mismatch("rdata", rdata, exp_rdata);
                end
            end

            if (bus.adstb) begin
                if (!xfer_armed) begin
                    report_failure("bus cycle started with no transfer expected");
                end else begin
                    if (bus.addr !== exp_addr) mismatch("addr", bus.addr, exp_addr);
                    if (dack !== (4'b0001 << exp_ch)) mismatch("dack", dack, 4'b0001 << exp_ch);
                    if (bus.aen !== 1'b1) mismatch("aen", bus.aen, 1);
                    if (strobes !== 4'b0000) mismatch("strobes", strobes, 0);
                end
                phase = 1;
            end else if (phase != 0) begin
                // S3 then S4
                if (xfer_armed) begin
                    if (strobes !== exp_strobes) mismatch("strobes", strobes, exp_strobes);
                    if (eop !== (phase == 2 && exp_eop)) begin
                        mismatch("eop", eop, phase == 2 && exp_eop);
                    end
                    if (bus.addr !== exp_addr) mismatch("addr", bus.addr, exp_addr);
                    if (dack !== (4'b0001 << exp_ch)) mismatch("dack", dack, 4'b0001 << exp_ch);
                    if (bus.aen !== 1'b1) mismatch("aen", bus.aen, 1);
                end
                phase = (phase == 2) ? 0 : 2;
            end else if (eop) begin
                report_failure("eop pulsed outside a transfer");
            end
        end
    end

endmodule

// File: sim/dma_controller_tb.sv
module dma_controller_tb;

    localparam int TIMEOUT    = 200;
    localparam int QUIET_WAIT = 40;

    typedef enum logic [2:0] {K_WR, K_RD, K_XFER, K_NO_HRQ, K_DREQ, K_END} step_kind_t;

    // Read steps keep the expected byte in data, end steps the test index
    typedef struct packed {
        step_kind_t     kind;
        logic [3:0]     addr;
        logic [7:0]     data;
        logic [3:0]     dreq;
        logic [3:0]     dreq_after;
        logic [1:0]     ch;
        logic [15:0]    exp_addr;
        dma_pkg::xfer_t xfer;
        logic           eop;
    } step_t;

    logic                       clk;
    logic                       reset;
    dma_pkg::cpu_req_t          cpu;
    logic [7:0]                 rdata;
    logic                       rdata_valid;
    logic [3:0]                 dreq;
    logic                       hlda;
    logic                       hrq;
    logic [3:0]                 dack;
    dma_pkg::dma_bus_t          bus;
    logic                       eop;
    logic                       rd_armed;
    logic [7:0]                 exp_rdata;
    logic                       xfer_armed;
    logic [1:0]                 exp_ch;
    logic [15:0]                exp_addr;
    dma_pkg::xfer_t             exp_xfer;
    logic                       exp_eop;
    logic [31:0]                lcg_state = 32'ha9cc;
    step_t                      steps [$];
    int                         hlda_wait;
    logic                       hlda_armed;

    dma_controller u_dma_controller (
        .clk(clk), .reset(reset), .cpu(cpu), .rdata(rdata), .rdata_valid(rdata_valid),
        .dreq(dreq), .hlda(hlda), .hrq(hrq), .dack(dack), .bus(bus), .eop(eop)
    );

    dma_checker u_check (
        .clk(clk), .reset(reset), .rdata(rdata), .rdata_valid(rdata_valid), .dack(dack),
        .bus(bus), .eop(eop), .rd_armed(rd_armed), .exp_rdata(exp_rdata),
        .xfer_armed(xfer_armed), .exp_ch(exp_ch), .exp_addr(exp_addr),
        .exp_xfer(exp_xfer), .exp_eop(exp_eop)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Bus master answers hrq after 1 to 8 cycles
    always @(posedge clk) begin
        logic [31:0] r;
        if (reset || !hrq) begin
            hlda <= 1'b0;
            hlda_armed = 1'b0;
        end else if (!hlda) begin
            if (!hlda_armed) begin
                r = lcg_next();
                hlda_wait = int'(r[18:16]);
                hlda_armed = 1'b1;
            end else if (hlda_wait == 0) begin
                hlda <= 1'b1;
            end else begin
                hlda_wait--;
            end
        end
    end

    function automatic dma_pkg::cpu_req_t make_cpu(logic wr, logic rd, logic [3:0] addr,
                                                   logic [7:0] data);
        dma_pkg::cpu_req_t c;
        c.wr   = wr;
        c.rd   = rd;
        c.addr = dma_pkg::reg_addr_t'(addr);
        c.data = data;
        return c;
    endfunction

    function automatic void push(step_kind_t kind, logic [3:0] addr, logic [7:0] data,
                                 logic [3:0] dq, logic [3:0] dq_after, logic [1:0] ch,
                                 logic [15:0] ea, dma_pkg::xfer_t xf, logic e);
        step_t s;
        s.kind       = kind;
        s.addr       = addr;
        s.data       = data;
        s.dreq       = dq;
        s.dreq_after = dq_after;
        s.ch         = ch;
        s.exp_addr   = ea;
        s.xfer       = xf;
        s.eop        = e;
        steps.push_back(s);
    endfunction

    function automatic void add_wr(logic [3:0] addr, logic [7:0] data);
        push(K_WR, addr, data, 0, 0, 0, 0, dma_pkg::XFER_VERIFY, 0);
    endfunction

    function automatic void add_rd(logic [3:0] addr, logic [7:0] exp);
        push(K_RD, addr, exp, 0, 0, 0, 0, dma_pkg::XFER_VERIFY, 0);
    endfunction

    function automatic void add_xfer(logic [3:0] dq, logic [3:0] dq_after, logic [1:0] ch,
                                     logic [15:0] ea, dma_pkg::xfer_t xf, logic e);
        push(K_XFER, 0, 0, dq, dq_after, ch, ea, xf, e);
    endfunction

    function automatic void add_plain(step_kind_t kind, logic [7:0] data, logic [3:0] dq);
        push(kind, 0, data, dq, 0, 0, 0, dma_pkg::XFER_VERIFY, 0);
    endfunction

    function automatic void add_program(logic [1:0] ch, logic [15:0] base, logic [15:0] count);
        add_wr({1'b0, ch, 1'b0}, base[7:0]);
        add_wr({1'b0, ch, 1'b0}, base[15:8]);
        add_wr({1'b0, ch, 1'b1}, count[7:0]);
        add_wr({1'b0, ch, 1'b1}, count[15:8]);
    endfunction

    function automatic string test_name(int idx);
        case (idx)
            0: return "programming and readback";
            1: return "incrementing write";
            2: return "autoinit with decrement";
            3: return "fixed priority";
            4: return "software request verify";
            default: return "disable and master clear";
        endcase
    endfunction

    task automatic build_table();
        logic [15:0] base [5];
        logic [31:0] r;
        for (int i = 0; i < 5; i++) begin
            r = lcg_next();
            base[i] = r[23:8];
        end
        add_program(0, base[0], 16'd5);
        add_rd(0, base[0][7:0]);
        add_rd(0, base[0][15:8]);
        add_rd(1, 8'd5);
        add_rd(1, 8'd0);
        add_rd(0, base[0][7:0]);
        add_wr(12, 0);
        add_rd(0, base[0][7:0]);
        add_rd(0, base[0][15:8]);
        add_plain(K_END, 0, 0);

        add_program(1, base[1], 16'd3);
        add_wr(11, 8'h05);
        add_wr(10, 8'h01);
        for (int i = 0; i < 4; i++) begin
            add_xfer(4'b0010, 4'b0010, 1, base[1] + 16'(i), dma_pkg::XFER_WRITE, i == 3);
        end
        add_plain(K_NO_HRQ, 0, 0);
        add_rd(8, 8'h22);
        add_rd(8, 8'h20);
        add_plain(K_DREQ, 0, 4'b0000);
        add_plain(K_END, 1, 0);

        add_program(2, base[2], 16'd1);
        add_wr(11, 8'h3a);
        add_wr(10, 8'h02);
        add_xfer(4'b0100, 4'b0100, 2, base[2], dma_pkg::XFER_READ, 0);
        add_xfer(4'b0100, 4'b0100, 2, base[2] - 16'd1, dma_pkg::XFER_READ, 1);
        add_xfer(4'b0100, 4'b0000, 2, base[2], dma_pkg::XFER_READ, 0);
        add_rd(8, 8'h04);
        add_plain(K_END, 2, 0);

        add_program(3, base[3], 16'd0);
        add_wr(11, 8'h0b);
        add_wr(11, 8'h04);
        add_wr(10, 8'h00);
        add_wr(10, 8'h03);
        add_xfer(4'b1001, 4'b0000, 0, base[0], dma_pkg::XFER_WRITE, 0);
        add_wr(10, 8'h04);
        add_xfer(4'b1001, 4'b0000, 3, base[3], dma_pkg::XFER_READ, 1);
        add_plain(K_END, 3, 0);

        add_wr(11, 8'h02);
        add_wr(10, 8'h06);
        add_program(2, base[4], 16'd0);
        add_wr(9, 8'h06);
        add_xfer(4'b0000, 4'b0000, 2, base[4], dma_pkg::XFER_VERIFY, 1);
        add_plain(K_NO_HRQ, 0, 0);
        add_rd(8, 8'h0c);
        add_plain(K_END, 4, 0);

        add_wr(8, 8'h04);
        add_wr(14, 0);
        add_plain(K_DREQ, 0, 4'b0001);
        add_plain(K_NO_HRQ, 0, 0);
        add_wr(13, 0);
        add_plain(K_NO_HRQ, 0, 0);
        add_wr(14, 0);
        add_xfer(4'b0001, 4'b0000, 0, base[0] + 16'd1, dma_pkg::XFER_WRITE, 0);
        add_plain(K_END, 5, 0);
    endtask

    task automatic run_step(input step_t s);
        int n;
        n = 0;
        case (s.kind)
            K_WR: begin
                @(posedge clk);
                cpu <= make_cpu(1'b1, 1'b0, s.addr, s.data);
                @(posedge clk);
                cpu <= '0;
            end
            K_RD: begin
                @(posedge clk);
                cpu       <= make_cpu(1'b0, 1'b1, s.addr, 8'h00);
                exp_rdata <= s.data;
                rd_armed  <= 1'b1;
                @(posedge clk);
                cpu <= '0;
                do begin
                    @(posedge clk);
                    n++;
                end while (!rdata_valid && n < TIMEOUT);
                if (!rdata_valid) u_check.report_failure("no read data came back");
                rd_armed <= 1'b0;
            end
            K_XFER: begin
                @(posedge clk);
                dreq       <= s.dreq;
                exp_ch     <= s.ch;
                exp_addr   <= s.exp_addr;
                exp_xfer   <= s.xfer;
                exp_eop    <= s.eop;
                xfer_armed <= 1'b1;
                do begin
                    @(posedge clk);
                    n++;
                end while (!bus.adstb && n < TIMEOUT);
                if (!bus.adstb) u_check.report_failure("expected transfer never started");
                dreq <= s.dreq_after;
                n = 0;
                do begin
                    @(posedge clk);
                    n++;
                end while (hrq && n < TIMEOUT);
                if (hrq) u_check.report_failure("hrq stayed high after the transfer");
                xfer_armed <= 1'b0;
            end
            K_NO_HRQ: begin
                while (n < QUIET_WAIT) begin
                    @(posedge clk);
                    n++;
                    if (hrq) begin
                        u_check.report_failure("hrq raised while no channel may be served");
                        n = QUIET_WAIT;
                    end
                end
            end
            K_DREQ: begin
                @(posedge clk);
                dreq <= s.dreq;
            end
            default: begin
                @(negedge clk);
                u_check.end_test(test_name(s.data));
            end
        endcase
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        cpu        = '0;
        dreq       = '0;
        hlda       = 1'b0;
        rd_armed   = 1'b0;
        exp_rdata  = '0;
        xfer_armed = 1'b0;
        exp_ch     = '0;
        exp_addr   = '0;
        exp_xfer   = dma_pkg::XFER_VERIFY;
        exp_eop    = 1'b0;
        build_table();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        foreach (steps[i]) begin
            run_step(steps[i]);
        end
        @(negedge clk);
        u_check.close_run();
        if (u_check.err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: dma_controller.f
hw/dma_pkg.sv
hw/dma_channel.sv
hw/dma_arbiter.sv
hw/dma_cpu_port.sv
hw/dma_cycle_fsm.sv
hw/dma_controller.sv
sim/dma_checker.sv
sim/dma_controller_tb.sv

// File: Bender.yml
package:
  name: dma_controller

sources:
  - hw/dma_pkg.sv
  - hw/dma_channel.sv
  - hw/dma_arbiter.sv
  - hw/dma_cpu_port.sv
  - hw/dma_cycle_fsm.sv
  - hw/dma_controller.sv
  - target: simulation
    files:
      - sim/dma_checker.sv
      - sim/dma_controller_tb.sv
